// File: verilog/arith_types_pkg.sv
package arith_types_pkg;

    localparam int WORD_W  = 32;
    localparam int DWORD_W = 2 * WORD_W;
    localparam int CNT_W   = 6;

    // Operand or result word
    typedef logic [WORD_W-1:0] word_t;

    // Remainder:quotient pair or full product
    typedef logic [DWORD_W-1:0] dword_t;

    // Partial remainder with guard bit
    typedef logic [WORD_W:0] part_t;

    typedef logic [CNT_W-1:0] count_t;  // Iteration counter

    // One iteration per operand bit
    localparam count_t STEPS = count_t'(WORD_W);

endpackage : arith_types_pkg

// File: verilog/muldiv_ctrl_pkg.sv
package muldiv_ctrl_pkg;

    localparam int OP_DIV_BIT = 1;  // High op bit selects divider

    typedef enum logic [1:0] {
        OP_MUL_LO = 2'b00,
        OP_MUL_HI = 2'b01,
        OP_DIV_Q  = 2'b10,
        OP_DIV_R  = 2'b11
    } op_t;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'b00,
        DIV_RUN  = 2'b01,
        DIV_DONE = 2'b10
    } div_state_t;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'b00,
        MUL_RUN  = 2'b01,
        MUL_DONE = 2'b10
    } mul_state_t;

endpackage : muldiv_ctrl_pkg

// File: verilog/shift_reg.sv
module shift_reg (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ld,
    input  logic                    ld_parallel,
    input  logic                    ld_parallel_shift,
    input  logic                    bit_in,
    input  arith_types_pkg::dword_t z_in,
    output arith_types_pkg::dword_t z_out
);

    arith_types_pkg::dword_t load_shifted;
    arith_types_pkg::dword_t self_shifted;

    // Shift left by one, new bit at the bottom
    assign load_shifted = {z_in[62:0], bit_in};
    assign self_shifted = {z_out[62:0], bit_in};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            z_out <= '0;
        end
        else if (ld_parallel) begin
            z_out <= z_in;
        end
        else if (ld_parallel_shift) begin
            z_out <= load_shifted;  // Update then shift in one step
        end
        else if (ld) begin
            z_out <= self_shifted;
        end
    end

endmodule : shift_reg

// File: verilog/divider_slow.sv
module divider_slow (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   new_instruction,
    input  arith_types_pkg::word_t a,
    input  arith_types_pkg::word_t b,
    output arith_types_pkg::word_t q,
    output arith_types_pkg::word_t r,
    output logic                   done
);

    muldiv_ctrl_pkg::div_state_t state, next_state;

    arith_types_pkg::count_t count;
    arith_types_pkg::word_t  divisor;   // Captured so the core may move b
    arith_types_pkg::dword_t z_in;
    arith_types_pkg::dword_t z_out;
    arith_types_pkg::part_t  part_rem;
    arith_types_pkg::part_t  part_div;
    arith_types_pkg::part_t  diff;

    logic ld;
    logic ld_parallel;
    logic ld_parallel_shift;
    logic bit_in;
    logic fits;
    logic last;

    shift_reg work_reg (
        .clk               (clk),
        .rst               (rst),
        .ld                (ld),
        .ld_parallel       (ld_parallel),
        .ld_parallel_shift (ld_parallel_shift),
        .bit_in            (bit_in),
        .z_in              (z_in),
        .z_out             (z_out)
    );

    // Remainder with the next dividend bit already brought down
    assign part_rem = z_out[63:31];
    assign part_div = {1'b0, divisor};
    assign diff     = part_rem - part_div;
    assign fits     = (part_rem >= part_div);
    assign last     = (count == arith_types_pkg::STEPS);

    always_comb begin : div_strobes
        ld                = 1'b0;
        ld_parallel       = 1'b0;
        ld_parallel_shift = 1'b0;
        bit_in            = 1'b0;
        z_in              = z_out;
        case (state)
            muldiv_ctrl_pkg::DIV_IDLE: begin
                z_in        = {32'b0, a};
                ld_parallel = start;
            end
            muldiv_ctrl_pkg::DIV_RUN: begin
                if (!last) begin
                    if (fits) begin
                        z_in              = {diff, z_out[30:0]};  // Guard bit drops on shift
                        bit_in            = 1'b1;
                        ld_parallel_shift = 1'b1;
                    end
                    else begin
                        ld = 1'b1;  // Quotient bit 0
                    end
                end
            end
            default: ;
        endcase
    end

    always_comb begin : div_next_state
        next_state = state;
        case (state)
            muldiv_ctrl_pkg::DIV_IDLE: begin
                if (start) begin
                    next_state = muldiv_ctrl_pkg::DIV_RUN;
                end
            end
            muldiv_ctrl_pkg::DIV_RUN: begin
                if (last) begin
                    next_state = muldiv_ctrl_pkg::DIV_DONE;
                end
            end
            muldiv_ctrl_pkg::DIV_DONE: begin
                if (new_instruction) begin
                    next_state = muldiv_ctrl_pkg::DIV_IDLE;
                end
            end
            default: next_state = muldiv_ctrl_pkg::DIV_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= muldiv_ctrl_pkg::DIV_IDLE;
            count   <= '0;
            divisor <= '0;
        end
        else begin
            state <= next_state;
            if (state == muldiv_ctrl_pkg::DIV_IDLE && start) begin
                count   <= '0;
                divisor <= b;
            end
            else if (state == muldiv_ctrl_pkg::DIV_RUN && !last) begin
                count <= count + 6'd1;
            end
        end
    end

    assign done = (state == muldiv_ctrl_pkg::DIV_DONE);
    assign q    = done ? z_out[31:0] : '0;
    assign r    = done ? z_out[63:32] : '0;

endmodule : divider_slow

// File: verilog/multiplier_slow.sv
module multiplier_slow (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   new_instruction,
    input  arith_types_pkg::word_t a,
    input  arith_types_pkg::word_t b,
    output arith_types_pkg::word_t lo,
    output arith_types_pkg::word_t hi,
    output logic                   done
);

    muldiv_ctrl_pkg::mul_state_t state, next_state;

    arith_types_pkg::count_t count;
    arith_types_pkg::word_t  mcand;
    arith_types_pkg::word_t  mplier;    // Consumed from the top bit down
    arith_types_pkg::dword_t z_in;
    arith_types_pkg::dword_t z_out;

    logic ld;
    logic ld_parallel;
    logic ld_parallel_shift;
    logic bit_in;
    logic last;

    shift_reg prod_reg (
        .clk               (clk),
        .rst               (rst),
        .ld                (ld),
        .ld_parallel       (ld_parallel),
        .ld_parallel_shift (ld_parallel_shift),
        .bit_in            (bit_in),
        .z_in              (z_in),
        .z_out             (z_out)
    );

    assign last = (count == arith_types_pkg::STEPS);

    // 2P + a is formed as ((P + a/2) << 1) with a[0] shifted in
    always_comb begin : mul_strobes
        ld                = 1'b0;
        ld_parallel       = 1'b0;
        ld_parallel_shift = 1'b0;
        bit_in            = 1'b0;
        z_in              = '0;
        case (state)
            muldiv_ctrl_pkg::MUL_IDLE: begin
                ld_parallel = start;  // Clear product
            end
            muldiv_ctrl_pkg::MUL_RUN: begin
                if (!last) begin
                    if (mplier[31]) begin
                        z_in              = z_out + {33'b0, mcand[31:1]};
                        bit_in            = mcand[0];
                        ld_parallel_shift = 1'b1;
                    end
                    else begin
                        ld = 1'b1;
                    end
                end
            end
            default: ;
        endcase
    end

    always_comb begin : mul_next_state
        next_state = state;
        case (state)
            muldiv_ctrl_pkg::MUL_IDLE: begin
                if (start) begin
                    next_state = muldiv_ctrl_pkg::MUL_RUN;
                end
            end
            muldiv_ctrl_pkg::MUL_RUN: begin
                if (last) begin
                    next_state = muldiv_ctrl_pkg::MUL_DONE;
                end
            end
            muldiv_ctrl_pkg::MUL_DONE: begin
                if (new_instruction) begin
                    next_state = muldiv_ctrl_pkg::MUL_IDLE;
                end
            end
            default: next_state = muldiv_ctrl_pkg::MUL_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= muldiv_ctrl_pkg::MUL_IDLE;
            count  <= '0;
            mcand  <= '0;
            mplier <= '0;
        end
        else begin
            state <= next_state;
            if (state == muldiv_ctrl_pkg::MUL_IDLE && start) begin
                count  <= '0;
                mcand  <= a;
                mplier <= b;
            end
            else if (state == muldiv_ctrl_pkg::MUL_RUN && !last) begin
                count  <= count + 6'd1;
                mplier <= {mplier[30:0], 1'b0};
            end
        end
    end

    assign done = (state == muldiv_ctrl_pkg::MUL_DONE);
    assign lo   = done ? z_out[31:0] : '0;
    assign hi   = done ? z_out[63:32] : '0;

endmodule : multiplier_slow

// File: verilog/muldiv_unit.sv
module muldiv_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   new_instruction,
    input  muldiv_ctrl_pkg::op_t   op,
    input  arith_types_pkg::word_t a,
    input  arith_types_pkg::word_t b,
    output arith_types_pkg::word_t result,
    output logic                   done
);

    muldiv_ctrl_pkg::op_t op_q;     // Op of the accepted request

    arith_types_pkg::word_t q;
    arith_types_pkg::word_t r;
    arith_types_pkg::word_t lo;
    arith_types_pkg::word_t hi;

    logic busy;
    logic accept;
    logic div_start;
    logic mul_start;
    logic div_done;
    logic mul_done;

    assign accept    = start && !busy;
    assign div_start = accept && op[muldiv_ctrl_pkg::OP_DIV_BIT];
    assign mul_start = accept && !op[muldiv_ctrl_pkg::OP_DIV_BIT];

    divider_slow div_engine (
        .clk             (clk),
        .rst             (rst),
        .start           (div_start),
        .new_instruction (new_instruction),
        .a               (a),
        .b               (b),
        .q               (q),
        .r               (r),
        .done            (div_done)
    );

    multiplier_slow mul_engine (
        .clk             (clk),
        .rst             (rst),
        .start           (mul_start),
        .new_instruction (new_instruction),
        .a               (a),
        .b               (b),
        .lo              (lo),
        .hi              (hi),
        .done            (mul_done)
    );

    assign done = div_done | mul_done;

    // Busy from accept until the core takes the result
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            op_q <= muldiv_ctrl_pkg::OP_MUL_LO;
        end
        else if (accept) begin
            busy <= 1'b1;
            op_q <= op;
        end
        else if (done && new_instruction) begin
            busy <= 1'b0;
        end
    end

    // Idle engines drive zero, so result is zero until done
    always_comb begin : result_mux
        result = '0;
        case (op_q)
            muldiv_ctrl_pkg::OP_MUL_LO: result = lo;
            muldiv_ctrl_pkg::OP_MUL_HI: result = hi;
            muldiv_ctrl_pkg::OP_DIV_Q:  result = q;
            muldiv_ctrl_pkg::OP_DIV_R:  result = r;
            default: ;
        endcase
    end

endmodule : muldiv_unit

// File: verification/muldiv_tb.sv
module muldiv_tb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int RUN_CYCLES     = 33;  // Start edge to done
    localparam int RANDOM_OPS     = 40;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic                   new_instruction;
    muldiv_ctrl_pkg::op_t   op;
    arith_types_pkg::word_t a;
    arith_types_pkg::word_t b;
    arith_types_pkg::word_t result;
    logic                   done;

    int seed          = 32'h792e;
    int value_errors  = 0;
    int timing_errors = 0;
    int ops_done      = 0;
    bit timed_out     = 1'b0;

    // Reference model stepped on the same edges as the DUT
    logic                   started;
    logic                   model_busy;
    logic                   model_done;
    int                     model_cnt;
    muldiv_ctrl_pkg::op_t   model_op;
    arith_types_pkg::word_t model_a;
    arith_types_pkg::word_t model_b;
    arith_types_pkg::word_t exp_result;

    arith_types_pkg::word_t corner_a [8] = '{32'h0, 32'h1, 32'hffff_ffff, 32'hffff_ffff,
                                              32'h5, 32'h0003_0039, 32'h0, 32'hffff_ffff};
    arith_types_pkg::word_t corner_b [8] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h1,
                                              32'h7, 32'h0, 32'h5, 32'h0};

    muldiv_unit UUT (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .new_instruction (new_instruction),
        .op              (op),
        .a               (a),
        .b               (b),
        .result          (result),
        .done            (done)
    );

    always #2 clk = ~clk;

    function automatic arith_types_pkg::word_t expected_result(
        input muldiv_ctrl_pkg::op_t   f_op,
        input arith_types_pkg::word_t f_a,
        input arith_types_pkg::word_t f_b
    );
        arith_types_pkg::dword_t prod;
        prod = {32'b0, f_a} * {32'b0, f_b};
        case (f_op)
            muldiv_ctrl_pkg::OP_MUL_LO: return prod[31:0];
            muldiv_ctrl_pkg::OP_MUL_HI: return prod[63:32];
            muldiv_ctrl_pkg::OP_DIV_Q:  return (f_b == 0) ? 32'hffff_ffff : f_a / f_b;
            default:                    return (f_b == 0) ? f_a : f_a % f_b;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            started    <= 1'b0;
            model_busy <= 1'b0;
            model_done <= 1'b0;
            model_cnt  <= 0;
            model_op   <= muldiv_ctrl_pkg::OP_MUL_LO;
            model_a    <= '0;
            model_b    <= '0;
            exp_result <= '0;
        end
        else if (!model_busy) begin
            if (start) begin  // Accepted only when idle
                started    <= 1'b1;
                model_busy <= 1'b1;
                model_cnt  <= 0;
                model_op   <= op;
                model_a    <= a;
                model_b    <= b;
                exp_result <= expected_result(op, a, b);
            end
        end
        else if (!model_done) begin
            model_cnt <= model_cnt + 1;
            if (model_cnt == RUN_CYCLES - 1) begin
                model_done <= 1'b1;
            end
        end
        else if (new_instruction) begin
            model_busy <= 1'b0;
            model_done <= 1'b0;
            ops_done   <= ops_done + 1;
        end
    end

    reset_done_low: assert property (@(posedge clk) disable iff (rst)
        !started |-> done == 1'b0)
        else begin
            value_errors = value_errors + 1;
            $display("ERROR at %0t: done expected 0 got %b", $time, $sampled(done));
        end

    reset_result_zero: assert property (@(posedge clk) disable iff (rst)
        !started |-> result == '0)
        else begin
            value_errors = value_errors + 1;
            $display("ERROR at %0t: result expected %h got %h", $time, 32'h0, $sampled(result));
        end

    done_timing: assert property (@(posedge clk) disable iff (rst)
        done == model_done)
        else begin
            timing_errors = timing_errors + 1;
            $display("ERROR at %0t: done expected %b got %b", $time,
                     $sampled(model_done), $sampled(done));
        end

    result_value: assert property (@(posedge clk) disable iff (rst)
        (done && model_done) |-> result == exp_result)
        else begin
            value_errors = value_errors + 1;
            $display("ERROR at %0t: result (op %0d) expected %h got %h", $time,
                     $sampled(model_op), $sampled(exp_result), $sampled(result));
        end

    div_zero_quotient: assert property (@(posedge clk) disable iff (rst)
        (done && model_done && model_b == 0 && model_op == muldiv_ctrl_pkg::OP_DIV_Q)
        |-> result == 32'hffff_ffff)
        else begin
            value_errors = value_errors + 1;
            $display("ERROR at %0t: result (quotient by zero) expected %h got %h", $time,
                     32'hffff_ffff, $sampled(result));
        end

    div_zero_remainder: assert property (@(posedge clk) disable iff (rst)
        (done && model_done && model_b == 0 && model_op == muldiv_ctrl_pkg::OP_DIV_R)
        |-> result == model_a)
        else begin
            value_errors = value_errors + 1;
            $display("ERROR at %0t: result (remainder by zero) expected %h got %h", $time,
                     $sampled(model_a), $sampled(result));
        end

    result_stable: assert property (@(posedge clk) disable iff (rst)
        (done && $past(done)) |-> result == $past(result))
        else begin
            value_errors = value_errors + 1;
            $display("ERROR at %0t: result expected %h (held) got %h", $time,
                     $past(result), $sampled(result));
        end

    task automatic report_counts();
        $display("Operations %0d, value errors %0d, timing errors %0d",
                 ops_done, value_errors, timing_errors);
    endtask

    task automatic random_op(output muldiv_ctrl_pkg::op_t r_op);
        logic [31:0] rnd;
        rnd  = $random(seed);
        r_op = muldiv_ctrl_pkg::op_t'(rnd[1:0]);
    endtask

    // Called one unit after an edge with the unit idle; returns the same way
    task automatic run_op(
        input muldiv_ctrl_pkg::op_t   t_op,
        input arith_types_pkg::word_t t_a,
        input arith_types_pkg::word_t t_b,
        input bit                     noise
    );
        int cycles;
        int hold;
        if (timed_out) begin
            return;
        end
        cycles = 0;
        start  = 1'b1;
        op     = t_op;
        a      = t_a;
        b      = t_b;
        @(posedge clk);
        #1;
        start = 1'b0;
        a     = $random(seed);  // Operands were captured on the start edge
        b     = $random(seed);
        while (!done && cycles < TIMEOUT_CYCLES) begin
            start           = noise && (cycles == 5);  // Ignored while busy
            new_instruction = noise && (cycles == 12);  // No effect before done
            if (start) begin
                random_op(op);
            end
            @(posedge clk);
            #1;
            cycles = cycles + 1;
        end
        start           = 1'b0;
        new_instruction = 1'b0;
        if (!done) begin
            $display("Timeout: done did not rise within %0d cycles of start", TIMEOUT_CYCLES);
            timed_out = 1'b1;
        end
        else begin
            hold = $unsigned($random(seed)) % 4;
            for (int i = 0; i < hold; i++) begin
                start = noise && (i == 0);  // Result must not change
                @(posedge clk);
                #1;
            end
            start           = 1'b0;
            new_instruction = 1'b1;
            @(posedge clk);
            #1;
            new_instruction = 1'b0;
        end
    endtask

    task automatic run_all_ops(
        input arith_types_pkg::word_t t_a,
        input arith_types_pkg::word_t t_b,
        input bit                     noise
    );
        run_op(muldiv_ctrl_pkg::OP_MUL_LO, t_a, t_b, noise);
        run_op(muldiv_ctrl_pkg::OP_MUL_HI, t_a, t_b, noise);
        run_op(muldiv_ctrl_pkg::OP_DIV_Q, t_a, t_b, noise);
        run_op(muldiv_ctrl_pkg::OP_DIV_R, t_a, t_b, noise);
    endtask

    initial begin
        muldiv_ctrl_pkg::op_t   r_op;
        arith_types_pkg::word_t r_a;
        arith_types_pkg::word_t r_b;
        logic [31:0]            rnd;
        clk             = 1'b0;
        rst             = 1'b1;
        start           = 1'b0;
        new_instruction = 1'b0;
        op              = muldiv_ctrl_pkg::OP_MUL_LO;
        a               = '0;
        b               = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        new_instruction = 1'b1;  // Acknowledge while idle
        @(posedge clk);
        #1;
        new_instruction = 1'b0;
        for (int i = 0; i < 8; i++) begin
            run_all_ops(corner_a[i], corner_b[i], i[0]);
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rnd = $random(seed);
            r_a = $random(seed);
            r_b = $random(seed);
            if (rnd[7:6] == 2'b00) begin
                r_b = r_b >> 20;  // Large quotients
            end
            random_op(r_op);
            run_op(r_op, r_a, r_b, rnd[4]);
        end
        report_counts();
        if (value_errors == 0 && timing_errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : muldiv_tb

// File: vlog.f
verilog/arith_types_pkg.sv
verilog/muldiv_ctrl_pkg.sv
verilog/shift_reg.sv
verilog/divider_slow.sv
verilog/multiplier_slow.sv
verilog/muldiv_unit.sv
verification/muldiv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the muldiv testbench with Verilator, run it and check the verdict

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module muldiv_tb -o muldiv_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/muldiv_sim | tee /dev/stderr | grep "Simulation passed" > /dev/null \
    && echo "Run OK" \
    || { echo "Run FAILED"; exit 1; }
